//--- logic/issue_cfg_pkg.sv
package issue_cfg_pkg;

    // architectural register file
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;

    // datapath and immediate widths
    localparam int XLEN  = 64;
    localparam int IMM_W = 32;

    // bundles offered by decode on every cycle
    localparam int NUM_SLOTS = 2;

    // a register address, as used for rs1, rs2 and rd
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // one bit per architectural register
    // used for operand masks and for the scoreboard itself
    typedef logic [NUM_REGS-1:0] reg_mask_t;

    // a full datapath word
    // immediates are sign extended to this width
    typedef logic [XLEN-1:0] xword_t;

endpackage

//--- logic/issue_bundle_pkg.sv
package issue_bundle_pkg;

    localparam int BUNDLE_W = 68;

    // field positions inside a decoded bundle
    // bit 0 carries nothing that the issue stage looks at
    localparam int RS1_LSB     = 1;
    localparam int RS2_LSB     = 6;
    localparam int RD_LSB      = 11;
    localparam int IMM_LSB     = 16;
    localparam int PIPE_LSB    = 48;
    localparam int OP2_SEL_BIT = 52;
    localparam int XARITH_LSB  = 53;
    localparam int XLOGIC_LSB  = 61;

    localparam int PIPE_W        = 4;
    localparam int XARITH_CTRL_W = 8;
    localparam int XLOGIC_CTRL_W = 7;

    typedef logic [BUNDLE_W-1:0] bundle_t;
    typedef logic [PIPE_W-1:0]   pipe_code_t;

    // only these two pipeline codes reach an execution unit
    localparam pipe_code_t PIPE_XARITH = 4'd1;
    localparam pipe_code_t PIPE_XLOGIC = 4'd2;

    // {word, branch_invert, branch_equal, cmp_mode, unsigned, sub, opsel[1:0]}
    typedef logic [XARITH_CTRL_W-1:0] xarith_ctrl_t;

    // {word, sll[1:0], invert, opsel[2:0]}
    typedef logic [XLOGIC_CTRL_W-1:0] xlogic_ctrl_t;

    // ISSUE_SECOND means bundle 0 has left and only bundle 1 is pending
    typedef enum logic {ISSUE_PAIR, ISSUE_SECOND} issue_state_e;

endpackage

//--- logic/slot_if.sv
`timescale 1ns/1ns

interface slot_if;
    import issue_cfg_pkg::*;
    import issue_bundle_pkg::*;

    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    xword_t       imm;
    logic         op2_sel;
    logic         is_xarith;
    logic         is_xlogic;
    xarith_ctrl_t xarith_ctrl;
    xlogic_ctrl_t xlogic_ctrl;
    reg_mask_t    rd_mask;
    // high when no operand of the slot is reserved in the scoreboard
    logic         clear;

    modport slot (output rs1, rs2, rd, imm, op2_sel, is_xarith, is_xlogic,
                  xarith_ctrl, xlogic_ctrl, rd_mask, clear);
    modport disp (input rs1, rs2, rd, imm, op2_sel, is_xarith, is_xlogic,
                  xarith_ctrl, xlogic_ctrl, rd_mask, clear);
endinterface

//--- logic/reservation_table.sv
`timescale 1ns/1ns

module reservation_table (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  issue_cfg_pkg::reg_mask_t i_reserve,
    input  issue_cfg_pkg::reg_mask_t i_retire,
    output issue_cfg_pkg::reg_mask_t o_reservation
);
    import issue_cfg_pkg::*;

    // x0 is hardwired to zero, so it can never hold a pending write
    localparam reg_mask_t X0_MASK = reg_mask_t'(1);

    reg_mask_t reservation_q;
    reg_mask_t reservation_d;

    // a bit that is retired and reserved in the same cycle stays set
    // because its new writer is still in flight
    assign reservation_d = ((reservation_q & ~i_retire) | i_reserve) & ~X0_MASK;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reservation_q <= '0;
        end else begin
            reservation_q <= reservation_d;
        end
    end

    assign o_reservation = reservation_q;

endmodule

//--- logic/issue_slot.sv
`timescale 1ns/1ns

module issue_slot (
    input  issue_bundle_pkg::bundle_t i_bundle,
    input  issue_cfg_pkg::reg_mask_t  i_reservation,
    slot_if.slot                      o_slot
);
    import issue_cfg_pkg::*;
    import issue_bundle_pkg::*;

    reg_addr_t          rs1;
    reg_addr_t          rs2;
    reg_addr_t          rd;
    logic [IMM_W-1:0]   imm32;
    pipe_code_t         pipe;
    logic               op2_sel;
    reg_mask_t          rs1_mask;
    reg_mask_t          rs2_mask;
    reg_mask_t          rd_mask;
    reg_mask_t          operand_mask;

    assign rs1     = i_bundle[RS1_LSB +: REG_ADDR_W];
    assign rs2     = i_bundle[RS2_LSB +: REG_ADDR_W];
    assign rd      = i_bundle[RD_LSB +: REG_ADDR_W];
    assign imm32   = i_bundle[IMM_LSB +: IMM_W];
    assign pipe    = i_bundle[PIPE_LSB +: PIPE_W];
    assign op2_sel = i_bundle[OP2_SEL_BIT];

    // one bit per operand, compared against the in-flight destinations
    // when op2 is the immediate, rs2 is never read and cannot cause a stall
    assign rs1_mask     = reg_mask_t'(1) << rs1;
    assign rs2_mask     = (reg_mask_t'(1) << rs2) & {NUM_REGS{!op2_sel}};
    assign rd_mask      = reg_mask_t'(1) << rd;
    assign operand_mask = rs1_mask | rs2_mask | rd_mask;

    assign o_slot.rs1     = rs1;
    assign o_slot.rs2     = rs2;
    assign o_slot.rd      = rd;
    assign o_slot.op2_sel = op2_sel;
    assign o_slot.rd_mask = rd_mask;

    // decode keeps the immediate narrow to save wiring and the slot widens it
    assign o_slot.imm = {{(XLEN - IMM_W){imm32[IMM_W-1]}}, imm32};

    assign o_slot.is_xarith = (pipe == PIPE_XARITH);
    assign o_slot.is_xlogic = (pipe == PIPE_XLOGIC);

    assign o_slot.xarith_ctrl = i_bundle[XARITH_LSB +: XARITH_CTRL_W];
    assign o_slot.xlogic_ctrl = i_bundle[XLOGIC_LSB +: XLOGIC_CTRL_W];

    // covers RAW on the sources and WAW on the destination
    assign o_slot.clear = ((operand_mask & i_reservation) == '0);

endmodule

//--- logic/dispatch_ctrl.sv
`timescale 1ns/1ns

module dispatch_ctrl (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_input_valid,
    input  logic                           i_xarith_ready,
    input  logic                           i_xlogic_ready,
    slot_if.disp                           i_slot0,
    slot_if.disp                           i_slot1,
    output issue_cfg_pkg::reg_mask_t       o_reserve,
    output logic                           o_input_ready,
    output issue_cfg_pkg::reg_addr_t       o_rs1_addr,
    output issue_cfg_pkg::reg_addr_t       o_rs2_addr,
    output issue_cfg_pkg::reg_addr_t       o_rs3_addr,
    output issue_cfg_pkg::reg_addr_t       o_rs4_addr,
    output logic                           o_xarith_banksel,
    output logic                           o_xarith_op2_sel,
    output issue_cfg_pkg::xword_t          o_xarith_imm,
    output issue_bundle_pkg::xarith_ctrl_t o_xarith_ctrl,
    output issue_cfg_pkg::reg_addr_t       o_xarith_rd,
    output logic                           o_xarith_valid,
    output logic                           o_xlogic_banksel,
    output logic                           o_xlogic_op2_sel,
    output issue_cfg_pkg::xword_t          o_xlogic_imm,
    output issue_bundle_pkg::xlogic_ctrl_t o_xlogic_ctrl,
    output issue_cfg_pkg::reg_addr_t       o_xlogic_rd,
    output logic                           o_xlogic_valid
);
    import issue_cfg_pkg::*;
    import issue_bundle_pkg::*;

    issue_state_e state_q;
    logic         done;
    logic         s0_tx_arith;
    logic         s0_tx_logic;
    logic         s0_tx;
    logic         s1_go;
    logic         s1_tx_arith;
    logic         s1_tx_logic;
    logic         s1_tx;

    assign done = (state_q == ISSUE_SECOND);

    // bundle 0 leaves once its operands are free and its unit can take it
    assign s0_tx_arith = i_input_valid && !done && i_slot0.clear
                         && i_slot0.is_xarith && i_xarith_ready;
    assign s0_tx_logic = i_input_valid && !done && i_slot0.clear
                         && i_slot0.is_xlogic && i_xlogic_ready;
    assign s0_tx       = s0_tx_arith || s0_tx_logic;

    // bundle 1 follows bundle 0 in order, never shares its unit in the same
    // cycle and never shares its rd while bundle 0 is still pending
    assign s1_go = i_input_valid && i_slot1.clear
                   && (done || (s0_tx && (i_slot0.rd != i_slot1.rd)));
    assign s1_tx_arith = s1_go && i_slot1.is_xarith && (done || !i_slot0.is_xarith)
                         && i_xarith_ready;
    assign s1_tx_logic = s1_go && i_slot1.is_xlogic && (done || !i_slot0.is_xlogic)
                         && i_xlogic_ready;
    assign s1_tx       = s1_tx_arith || s1_tx_logic;

    // the pair is consumed when its second bundle leaves
    assign o_input_ready = s1_tx;

    assign o_reserve = (i_slot0.rd_mask & {NUM_REGS{s0_tx}})
                     | (i_slot1.rd_mask & {NUM_REGS{s1_tx}});

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q        <= ISSUE_PAIR;
            o_xarith_valid <= 1'b0;
            o_xlogic_valid <= 1'b0;
        end else begin
            o_xarith_valid <= s0_tx_arith || s1_tx_arith;
            o_xlogic_valid <= s0_tx_logic || s1_tx_logic;
            if (s1_tx) begin
                state_q <= ISSUE_PAIR;
            end else if (s0_tx) begin
                state_q <= ISSUE_SECOND;
            end
        end
    end

    // register file reads happen on the edge where the bundles leave
    always_ff @(posedge i_clk) begin
        o_rs1_addr <= i_slot0.rs1;
        o_rs2_addr <= i_slot0.rs2;
        o_rs3_addr <= i_slot1.rs1;
        o_rs4_addr <= i_slot1.rs2;
        if (s0_tx_arith || s1_tx_arith) begin
            o_xarith_banksel <= s1_tx_arith;
            o_xarith_op2_sel <= s1_tx_arith ? i_slot1.op2_sel : i_slot0.op2_sel;
            o_xarith_imm     <= s1_tx_arith ? i_slot1.imm : i_slot0.imm;
            o_xarith_ctrl    <= s1_tx_arith ? i_slot1.xarith_ctrl : i_slot0.xarith_ctrl;
            o_xarith_rd      <= s1_tx_arith ? i_slot1.rd : i_slot0.rd;
        end
        if (s0_tx_logic || s1_tx_logic) begin
            o_xlogic_banksel <= s1_tx_logic;
            o_xlogic_op2_sel <= s1_tx_logic ? i_slot1.op2_sel : i_slot0.op2_sel;
            o_xlogic_imm     <= s1_tx_logic ? i_slot1.imm : i_slot0.imm;
            o_xlogic_ctrl    <= s1_tx_logic ? i_slot1.xlogic_ctrl : i_slot0.xlogic_ctrl;
            o_xlogic_rd      <= s1_tx_logic ? i_slot1.rd : i_slot0.rd;
        end
    end

endmodule

//--- logic/issue_top.sv
`timescale 1ns/1ns

module issue_top (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    // decoded pair from the front end
    input  logic                           i_input_valid,
    output logic                           o_input_ready,
    input  issue_bundle_pkg::bundle_t      i_bundle0,
    input  issue_bundle_pkg::bundle_t      i_bundle1,
    // register file read ports where rs3 and rs4 belong to bundle 1
    output issue_cfg_pkg::reg_addr_t       o_rs1_addr,
    output issue_cfg_pkg::reg_addr_t       o_rs2_addr,
    output issue_cfg_pkg::reg_addr_t       o_rs3_addr,
    output issue_cfg_pkg::reg_addr_t       o_rs4_addr,
    // integer arithmetic unit
    output logic                           o_xarith_banksel,
    output logic                           o_xarith_op2_sel,
    output issue_cfg_pkg::xword_t          o_xarith_imm,
    output issue_bundle_pkg::xarith_ctrl_t o_xarith_ctrl,
    output issue_cfg_pkg::reg_addr_t       o_xarith_rd,
    output logic                           o_xarith_valid,
    input  logic                           i_xarith_ready,
    // integer logic unit
    output logic                           o_xlogic_banksel,
    output logic                           o_xlogic_op2_sel,
    output issue_cfg_pkg::xword_t          o_xlogic_imm,
    output issue_bundle_pkg::xlogic_ctrl_t o_xlogic_ctrl,
    output issue_cfg_pkg::reg_addr_t       o_xlogic_rd,
    output logic                           o_xlogic_valid,
    input  logic                           i_xlogic_ready,
    // retire masks from the back end
    input  issue_cfg_pkg::reg_mask_t       i_inst0_retire,
    input  issue_cfg_pkg::reg_mask_t       i_inst1_retire
);
    import issue_cfg_pkg::*;
    import issue_bundle_pkg::*;

    bundle_t   bundles [NUM_SLOTS];
    reg_mask_t reservation;
    reg_mask_t reserve;
    reg_mask_t retire;

    assign bundles[0] = i_bundle0;
    assign bundles[1] = i_bundle1;
    assign retire     = i_inst0_retire | i_inst1_retire;

    slot_if slot_bus [NUM_SLOTS] ();

    reservation_table u_table (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_reserve     (reserve),
        .i_retire      (retire),
        .o_reservation (reservation)
    );

    for (genvar g = 0; g < NUM_SLOTS; g++) begin : gen_slot
        issue_slot u_slot (
            .i_bundle      (bundles[g]),
            .i_reservation (reservation),
            .o_slot        (slot_bus[g])
        );
    end

    dispatch_ctrl u_dispatch (
        .i_clk, .i_rst_n, .i_input_valid, .i_xarith_ready, .i_xlogic_ready,
        .i_slot0 (slot_bus[0]),
        .i_slot1 (slot_bus[1]),
        .o_reserve (reserve),
        .o_input_ready, .o_rs1_addr, .o_rs2_addr, .o_rs3_addr, .o_rs4_addr,
        .o_xarith_banksel, .o_xarith_op2_sel, .o_xarith_imm, .o_xarith_ctrl,
        .o_xarith_rd, .o_xarith_valid,
        .o_xlogic_banksel, .o_xlogic_op2_sel, .o_xlogic_imm, .o_xlogic_ctrl,
        .o_xlogic_rd, .o_xlogic_valid
    );

endmodule

//--- testbench/issue_sva.sv
`timescale 1ns/1ns

module issue_sva (
    input logic                     i_clk,
    input logic                     i_rst_n,
    input logic                     i_input_valid,
    input logic                     i_input_ready,
    input logic                     i_xarith_ready,
    input logic                     i_xarith_valid,
    input logic                     i_xlogic_ready,
    input logic                     i_xlogic_valid,
    input issue_cfg_pkg::reg_mask_t i_reservation
);

    // number of assertion failures seen so far
    int failures = 0;

    // a pending write to the hardwired x0 would stall its readers
    a_no_x0: assert property (@(posedge i_clk) disable iff (!i_rst_n) !i_reservation[0])
        else begin
            $error("scoreboard holds a reservation for x0");
            failures++;
        end

    // a unit only sees a valid after it was ready in the transmit cycle
    a_xarith_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_xarith_valid |-> $past(i_xarith_ready))
        else begin
            $error("xarith valid without ready in the previous cycle");
            failures++;
        end

    a_xlogic_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_xlogic_valid |-> $past(i_xlogic_ready))
        else begin
            $error("xlogic valid without ready in the previous cycle");
            failures++;
        end

    a_ready_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_input_ready |-> i_input_valid)
        else begin
            $error("input ready raised without an offered pair");
            failures++;
        end

endmodule

//--- testbench/tb_issue.sv
`timescale 1ns/1ns

module tb_issue;
    import issue_cfg_pkg::*;
    import issue_bundle_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 32'h3fbe;

    // register fields of one bundle
    // the immediate and control bits are drawn at random
    typedef struct packed {
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        pipe_code_t pipe;
        logic       op2;
    } slot_t;

    // one cycle of stimulus whose unit expectations belong to the following cycle
    // ret0 and ret1 name a retired register, where 0 means no retire
    typedef struct packed {
        slot_t     s0;
        slot_t     s1;
        logic      valid;
        logic      xa_rdy;
        logic      xl_rdy;
        reg_addr_t ret0;
        reg_addr_t ret1;
        logic      exp_ready;
        logic      xa_v;
        logic      xa_bank;
        reg_addr_t xa_rd;
        logic      xl_v;
        logic      xl_bank;
        reg_addr_t xl_rd;
    } row_t;

    logic         i_clk = 1'b0;
    logic         i_rst_n;
    logic         i_input_valid;
    logic         o_input_ready;
    bundle_t      i_bundle0;
    bundle_t      i_bundle1;
    reg_addr_t    o_rs1_addr, o_rs2_addr, o_rs3_addr, o_rs4_addr;
    logic         o_xarith_banksel, o_xarith_op2_sel, o_xarith_valid, i_xarith_ready;
    xword_t       o_xarith_imm;
    xarith_ctrl_t o_xarith_ctrl;
    reg_addr_t    o_xarith_rd;
    logic         o_xlogic_banksel, o_xlogic_op2_sel, o_xlogic_valid, i_xlogic_ready;
    xword_t       o_xlogic_imm;
    xlogic_ctrl_t o_xlogic_ctrl;
    reg_addr_t    o_xlogic_rd;
    reg_mask_t    i_inst0_retire, i_inst1_retire;

    row_t         rows[$];
    slot_t        pair0, pair1;
    logic [31:0]  imm_q [2];
    xarith_ctrl_t xa_ctrl_q [2];
    xlogic_ctrl_t xl_ctrl_q [2];
    int           checks = 0;
    int           errors = 0;
    int           cycles = 0;
    int           cycle_limit;

    issue_top u_dut (.*);

    bind issue_top issue_sva u_sva (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_input_valid  (i_input_valid),
        .i_input_ready  (o_input_ready),
        .i_xarith_ready (i_xarith_ready),
        .i_xarith_valid (o_xarith_valid),
        .i_xlogic_ready (i_xlogic_ready),
        .i_xlogic_valid (o_xlogic_valid),
        .i_reservation  (reservation)
    );

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the table did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic xword_t sext_imm(logic [31:0] imm);
        return {{32{imm[31]}}, imm};
    endfunction

    function automatic reg_mask_t retire_mask(reg_addr_t r);
        return (r == 0) ? '0 : reg_mask_t'(1) << r;
    endfunction

    function automatic bundle_t build_bundle(slot_t s, int idx);
        bundle_t b;
        b = '0;
        b[RS1_LSB +: REG_ADDR_W]       = s.rs1;
        b[RS2_LSB +: REG_ADDR_W]       = s.rs2;
        b[RD_LSB +: REG_ADDR_W]        = s.rd;
        b[IMM_LSB +: IMM_W]            = imm_q[idx];
        b[PIPE_LSB +: PIPE_W]          = s.pipe;
        b[OP2_SEL_BIT]                 = s.op2;
        b[XARITH_LSB +: XARITH_CTRL_W] = xa_ctrl_q[idx];
        b[XLOGIC_LSB +: XLOGIC_CTRL_W] = xl_ctrl_q[idx];
        return b;
    endfunction

    task automatic draw_fields();
        for (int b = 0; b < 2; b++) begin
            imm_q[b]     = $urandom();
            xa_ctrl_q[b] = xarith_ctrl_t'($urandom());
            xl_ctrl_q[b] = xlogic_ctrl_t'($urandom());
        end
    endtask

    task automatic apply_row(row_t r);
        i_input_valid  = r.valid;
        i_xarith_ready = r.xa_rdy;
        i_xlogic_ready = r.xl_rdy;
        i_inst0_retire = retire_mask(r.ret0);
        i_inst1_retire = retire_mask(r.ret1);
        i_bundle0      = build_bundle(r.s0, 0);
        i_bundle1      = build_bundle(r.s1, 1);
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        checks = checks + 1;
        assert (got === exp) else begin
            errors = errors + 1;
            $display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // registered outputs in the cycle after row r was presented
    task automatic check_outputs(row_t r);
        check_value("o_rs1_addr", 64'(o_rs1_addr), 64'(r.s0.rs1));
        check_value("o_rs2_addr", 64'(o_rs2_addr), 64'(r.s0.rs2));
        check_value("o_rs3_addr", 64'(o_rs3_addr), 64'(r.s1.rs1));
        check_value("o_rs4_addr", 64'(o_rs4_addr), 64'(r.s1.rs2));
        check_value("o_xarith_valid", 64'(o_xarith_valid), 64'(r.xa_v));
        if (r.xa_v) begin
            check_value("o_xarith_banksel", 64'(o_xarith_banksel), 64'(r.xa_bank));
            check_value("o_xarith_rd", 64'(o_xarith_rd), 64'(r.xa_rd));
            check_value("o_xarith_imm", o_xarith_imm, sext_imm(imm_q[r.xa_bank]));
            check_value("o_xarith_ctrl", 64'(o_xarith_ctrl), 64'(xa_ctrl_q[r.xa_bank]));
            check_value("o_xarith_op2_sel", 64'(o_xarith_op2_sel),
                        64'(r.xa_bank ? r.s1.op2 : r.s0.op2));
        end
        check_value("o_xlogic_valid", 64'(o_xlogic_valid), 64'(r.xl_v));
        if (r.xl_v) begin
            check_value("o_xlogic_banksel", 64'(o_xlogic_banksel), 64'(r.xl_bank));
            check_value("o_xlogic_rd", 64'(o_xlogic_rd), 64'(r.xl_rd));
            check_value("o_xlogic_imm", o_xlogic_imm, sext_imm(imm_q[r.xl_bank]));
            check_value("o_xlogic_ctrl", 64'(o_xlogic_ctrl), 64'(xl_ctrl_q[r.xl_bank]));
            check_value("o_xlogic_op2_sel", 64'(o_xlogic_op2_sel),
                        64'(r.xl_bank ? r.s1.op2 : r.s0.op2));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        i_rst_n        = 1'b0;
        i_input_valid  = 1'b0;
        i_bundle0      = '0;
        i_bundle1      = '0;
        i_xarith_ready = 1'b0;
        i_xlogic_ready = 1'b0;
        i_inst0_retire = '0;
        i_inst1_retire = '0;

        // after the pair come valid, xarith ready, xlogic ready, retire 0 and retire 1,
        // then input ready, then valid, banksel and rd for xarith and then for xlogic
        // independent pair, one bundle per unit
        pair0 = '{1, 2, 3, PIPE_XARITH, 0};
        pair1 = '{4, 5, 6, PIPE_XLOGIC, 1};
        rows.push_back(row_t'{pair0, pair1, 1, 1, 1, 0, 0, 1, 1, 0, 3, 1, 1, 6});
        // bundle 0 reads x3, which stays reserved until it retires
        pair0 = '{3, 1, 7, PIPE_XARITH, 1};
        pair1 = '{8, 9, 10, PIPE_XLOGIC, 0};
        rows.push_back(row_t'{pair0, pair1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back(row_t'{pair0, pair1, 1, 1, 1, 3, 6, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back(row_t'{pair0, pair1, 1, 1, 1, 0, 0, 1, 1, 0, 7, 1, 1, 10});
        // both bundles want xarith, so they leave one after the other
        pair0 = '{1, 2, 11, PIPE_XARITH, 0};
        pair1 = '{12, 13, 14, PIPE_XARITH, 0};
        rows.push_back(row_t'{pair0, pair1, 1, 1, 1, 7, 10, 0, 1, 0, 11, 0, 0, 0});
        // x14 is retired in the cycle it is reserved and has to stay reserved
        rows.push_back(row_t'{pair0, pair1, 1, 1, 1, 11, 14, 1, 1, 1, 14, 0, 0, 0});
        // both bundles write x15
        pair0 = '{1, 2, 15, PIPE_XARITH, 0};
        pair1 = '{16, 17, 15, PIPE_XLOGIC, 0};
        rows.push_back(row_t'{pair0, pair1, 1, 1, 1, 0, 0, 0, 1, 0, 15, 0, 0, 0});
        rows.push_back(row_t'{pair0, pair1, 1, 1, 1, 15, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back(row_t'{pair0, pair1, 1, 1, 1, 0, 0, 1, 0, 0, 0, 1, 1, 15});
        // xlogic holds off bundle 1 for two cycles
        pair0 = '{18, 19, 20, PIPE_XARITH, 0};
        pair1 = '{21, 22, 23, PIPE_XLOGIC, 0};
        rows.push_back(row_t'{pair0, pair1, 1, 1, 0, 15, 0, 0, 1, 0, 20, 0, 0, 0});
        rows.push_back(row_t'{pair0, pair1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back(row_t'{pair0, pair1, 1, 1, 1, 0, 0, 1, 0, 0, 0, 1, 1, 23});
        rows.push_back(row_t'{pair0, pair1, 0, 1, 1, 20, 23, 0, 0, 0, 0, 0, 0, 0});
        // immediate op2 hides the reserved x14, and bundle 1 writes x0
        pair0 = '{1, 14, 24, PIPE_XLOGIC, 1};
        pair1 = '{2, 3, 0, PIPE_XARITH, 0};
        rows.push_back(row_t'{pair0, pair1, 1, 1, 1, 0, 0, 1, 1, 1, 0, 1, 0, 24});
        // now x14 is a real rs2, and bundle 1 reads x0 only
        pair0 = '{0, 14, 25, PIPE_XARITH, 0};
        pair1 = '{0, 0, 26, PIPE_XLOGIC, 0};
        rows.push_back(row_t'{pair0, pair1, 1, 1, 1, 14, 24, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back(row_t'{pair0, pair1, 1, 1, 1, 0, 0, 1, 1, 0, 25, 1, 1, 26});
        cycle_limit = RESET_CYCLES + 4 * rows.size();

        repeat (RESET_CYCLES) @(negedge i_clk);
        i_rst_n = 1'b1;
        check_value("o_input_ready", 64'(o_input_ready), 64'(0));
        check_value("o_xarith_valid", 64'(o_xarith_valid), 64'(0));
        check_value("o_xlogic_valid", 64'(o_xlogic_valid), 64'(0));
        check_value("scoreboard", 64'(u_dut.reservation), 64'(0));

        for (int i = 0; i < rows.size(); i++) begin
            @(negedge i_clk);
            if (i > 0) begin
                check_outputs(rows[i - 1]);
            end
            // a held pair keeps its immediates and control bits
            if (i == 0 || rows[i - 1].exp_ready) begin
                draw_fields();
            end
            apply_row(rows[i]);
            #1;
            check_value("o_input_ready", 64'(o_input_ready), 64'(rows[i].exp_ready));
        end
        @(negedge i_clk);
        check_outputs(rows[rows.size() - 1]);

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, u_dut.u_sva.failures);
        if (errors == 0 && u_dut.u_sva.failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
logic/issue_cfg_pkg.sv
logic/issue_bundle_pkg.sv
logic/slot_if.sv
logic/reservation_table.sv
logic/issue_slot.sv
logic/dispatch_ctrl.sv
logic/issue_top.sv
testbench/issue_sva.sv
testbench/tb_issue.sv

//--- run.sh
#!/usr/bin/env bash
# build the issue stage testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_issue -f vlog.f -o tb_issue_sim

./obj_dir/tb_issue_sim | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
